// ==== Bender.yml ====
package:
  name: eth_rgmii_tester

sources:
  - files:
      - hw/eth_pkg.sv
      - hw/crc32_gmii.sv
      - hw/eth_test_ctrl.sv
      - hw/frame_tx.sv
      - hw/gmii_to_rgmii.sv
      - hw/frame_rx_check.sv
      - hw/eth_rgmii_tester.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_eth_rgmii_tester.sv

// ==== hw/crc32_gmii.sv ====
module crc32_gmii (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        init_i,   // load all ones
    input  logic        en_i,     // fold data_i in this cycle
    input  logic [7:0]  data_i,
    output logic [31:0] crc_o
);

    // reflected 802.3 polynomial
    localparam logic [31:0] poly = 32'hEDB88320;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // one byte per cycle, lsb first
    always_comb
    begin
        crc_next = crc_q ^ {24'h000000, data_i};
        for (int b = 0; b < 8; b++)
        begin
            if (crc_next[0])
                crc_next = (crc_next >> 1) ^ poly;
            else
                crc_next = crc_next >> 1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            crc_q <= '1;
        else if (init_i)
            crc_q <= '1;
        else if (en_i)
            crc_q <= crc_next;
    end

    assign crc_o = crc_q;

endmodule

// ==== hw/eth_pkg.sv ====
package eth_pkg;

    // frame layout
    localparam int          preamble_len = 7;           // 0x55 bytes before the sfd
    localparam logic [7:0]  sfd_byte     = 8'hD5;
    localparam int          ifg_cycles   = 12;          // idle cycles after the fcs

    // crc register after a good frame, fcs included (msb-first form)
    localparam logic [31:0] crc_residue  = 32'hC704DD7B;

    localparam int          max_len_w    = 11;          // payload length field

    // payload pattern opcodes
    typedef enum logic [1:0] {
        pat_incr,   // fill, fill+1, fill+2 ...
        pat_const,  // fill on every byte
        pat_err     // as pat_incr, tx_er on payload byte 0
    } pat_op_e;

    // transmit control states
    typedef enum logic [2:0] {
        tx_idle,
        tx_pre,
        tx_sfd,
        tx_data,
        tx_fcs,
        tx_gap
    } tx_state_e;

    typedef struct packed {
        pat_op_e              op;
        logic [max_len_w-1:0] len;   // 1 to 1500
        logic [7:0]           fill;
    } eth_cmd_t;

    typedef struct packed {
        logic [7:0] d;
        logic       en;   // tx_en or rx_dv
        logic       er;
    } gmii_t;

    typedef struct packed {
        logic [15:0]          good;
        logic [15:0]          bad;
        logic [max_len_w-1:0] last_len;
        logic [7:0]           last_xor;
    } rx_stat_t;

endpackage

// ==== hw/eth_rgmii_tester.sv ====
module eth_rgmii_tester #(
    parameter bit in_phase_tx_clk = 1'b0
) (
    input  logic              gmii_tx_clk_i,
    input  logic              gmii_tx_clk90_i,
    input  logic              rst_n_i,
    input  logic              start_i,        // one-cycle request
    input  eth_pkg::eth_cmd_t cmd_i,
    output logic [3:0]        rgmii_txd_o,
    output logic              rgmii_tx_ctl_o,
    output logic              rgmii_tx_clk_o,
    input  logic [3:0]        rgmii_rxd_i,
    input  logic              rgmii_rx_ctl_i,
    input  logic              rgmii_rx_clk_i,
    output logic              busy_o,
    output eth_pkg::rx_stat_t stat_o,         // rx clock domain
    output logic              rx_done_o       // rx clock domain
);

    eth_pkg::tx_state_e            phase;
    logic [eth_pkg::max_len_w-1:0] idx;
    eth_pkg::eth_cmd_t             cmd_lat;
    eth_pkg::gmii_t                gmii_tx;
    eth_pkg::gmii_t                gmii_rx;
    logic                          gmii_rx_clk;

    eth_test_ctrl u_eth_test_ctrl (
        .gmii_tx_clk_i (gmii_tx_clk_i),
        .rst_n_i       (rst_n_i),
        .start_i       (start_i),
        .cmd_i         (cmd_i),
        .phase_o       (phase),
        .idx_o         (idx),
        .cmd_o         (cmd_lat),
        .busy_o        (busy_o)
    );

    frame_tx u_frame_tx (
        .gmii_tx_clk_i (gmii_tx_clk_i),
        .rst_n_i       (rst_n_i),
        .phase_i       (phase),
        .idx_i         (idx),
        .cmd_i         (cmd_lat),
        .gmii_o        (gmii_tx)
    );

    gmii_to_rgmii #(
        .in_phase_tx_clk (in_phase_tx_clk)
    ) u_gmii_to_rgmii (
        .gmii_tx_clk_i   (gmii_tx_clk_i),
        .gmii_tx_clk90_i (gmii_tx_clk90_i),
        .rst_n_i         (rst_n_i),
        .gmii_tx_i       (gmii_tx),
        .rgmii_rxd_i     (rgmii_rxd_i),
        .rgmii_rx_ctl_i  (rgmii_rx_ctl_i),
        .rgmii_rx_clk_i  (rgmii_rx_clk_i),
        .rgmii_txd_o     (rgmii_txd_o),
        .rgmii_tx_ctl_o  (rgmii_tx_ctl_o),
        .rgmii_tx_clk_o  (rgmii_tx_clk_o),
        .gmii_rx_o       (gmii_rx),
        .gmii_rx_clk_o   (gmii_rx_clk)
    );

    frame_rx_check u_frame_rx_check (
        .gmii_rx_clk_i (gmii_rx_clk),
        .rst_n_i       (rst_n_i),
        .gmii_rx_i     (gmii_rx),
        .stat_o        (stat_o),
        .rx_done_o     (rx_done_o)
    );

endmodule

// ==== hw/eth_test_ctrl.sv ====
module eth_test_ctrl (
    input  logic                          gmii_tx_clk_i,
    input  logic                          rst_n_i,
    input  logic                          start_i,
    input  eth_pkg::eth_cmd_t             cmd_i,
    output eth_pkg::tx_state_e            phase_o,
    output logic [eth_pkg::max_len_w-1:0] idx_o,    // byte index within the phase
    output eth_pkg::eth_cmd_t             cmd_o,
    output logic                          busy_o
);

    localparam int unsigned idx_w = eth_pkg::max_len_w;

    // last index of each fixed-length phase
    localparam logic [idx_w-1:0] pre_last = idx_w'(eth_pkg::preamble_len - 1);
    localparam logic [idx_w-1:0] fcs_last = idx_w'(3);
    localparam logic [idx_w-1:0] gap_last = idx_w'(eth_pkg::ifg_cycles - 1);

    eth_pkg::tx_state_e state_q;
    eth_pkg::tx_state_e state_d;
    logic [idx_w-1:0]   idx_q;
    logic [idx_w-1:0]   idx_d;
    eth_pkg::eth_cmd_t  cmd_q;
    logic               accept;

    assign accept = (state_q == eth_pkg::tx_idle) && start_i;

    always_comb
    begin
        state_d = state_q;
        idx_d   = idx_q + idx_w'(1);
        unique case (state_q)
            eth_pkg::tx_idle:
            begin
                idx_d = '0;
                if (start_i)
                    state_d = eth_pkg::tx_pre;
            end
            eth_pkg::tx_pre:
            begin
                if (idx_q == pre_last)
                begin
                    state_d = eth_pkg::tx_sfd;
                    idx_d   = '0;
                end
            end
            eth_pkg::tx_sfd:
            begin
                state_d = eth_pkg::tx_data;  // single byte
                idx_d   = '0;
            end
            eth_pkg::tx_data:
            begin
                if (idx_q == cmd_q.len - idx_w'(1))
                begin
                    state_d = eth_pkg::tx_fcs;
                    idx_d   = '0;
                end
            end
            eth_pkg::tx_fcs:
            begin
                if (idx_q == fcs_last)
                begin
                    state_d = eth_pkg::tx_gap;
                    idx_d   = '0;
                end
            end
            eth_pkg::tx_gap:
            begin
                if (idx_q == gap_last)
                begin
                    state_d = eth_pkg::tx_idle;
                    idx_d   = '0;
                end
            end
            default:
            begin
                state_d = eth_pkg::tx_idle;
                idx_d   = '0;
            end
        endcase
    end

    always_ff @(posedge gmii_tx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q <= eth_pkg::tx_idle;
            idx_q   <= '0;
        end
        else
        begin
            state_q <= state_d;
            idx_q   <= idx_d;
        end
    end

    // command held for the whole frame
    always_ff @(posedge gmii_tx_clk_i)
    begin
        if (accept)
            cmd_q <= cmd_i;
    end

    assign phase_o = state_q;
    assign idx_o   = idx_q;
    assign cmd_o   = cmd_q;
    assign busy_o  = (state_q != eth_pkg::tx_idle);

endmodule

// ==== hw/frame_rx_check.sv ====
module frame_rx_check (
    input  logic              gmii_rx_clk_i,
    input  logic              rst_n_i,
    input  eth_pkg::gmii_t    gmii_rx_i,
    output eth_pkg::rx_stat_t stat_o,
    output logic              rx_done_o
);

    localparam int unsigned len_w = eth_pkg::max_len_w;

    logic                  in_frame_q;   // past the sfd
    logic                  err_seen_q;   // any rx_er while dv
    logic [len_w-1:0]      cnt_q;        // bytes after the sfd, fcs included
    logic [3:0][7:0]       dly_q;        // holds back the four fcs bytes
    logic [7:0]            xor_q;
    logic [31:0]           crc;
    logic [31:0]           crc_rev;
    logic                  frame_ok;
    logic                  done_q;
    eth_pkg::rx_stat_t     stat_q;

    // crc runs over payload and fcs
    crc32_gmii u_crc32_gmii (
        .clk_i   (gmii_rx_clk_i),
        .rst_n_i (rst_n_i),
        .init_i  (!in_frame_q),
        .en_i    (in_frame_q && gmii_rx_i.en),
        .data_i  (gmii_rx_i.d),
        .crc_o   (crc)
    );

    assign crc_rev  = {<<{crc}};  // residue constant is msb-first
    assign frame_ok = !err_seen_q
                      && (crc_rev == eth_pkg::crc_residue)
                      && (cnt_q >= len_w'(4));

    always_ff @(posedge gmii_rx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            in_frame_q <= 1'b0;
            err_seen_q <= 1'b0;
            cnt_q      <= '0;
            done_q     <= 1'b0;
            stat_q     <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (gmii_rx_i.en)
            begin
                if (gmii_rx_i.er)
                    err_seen_q <= 1'b1;
                if (in_frame_q)
                    cnt_q <= cnt_q + len_w'(1);
                else if (gmii_rx_i.d == eth_pkg::sfd_byte)
                begin
                    in_frame_q <= 1'b1;
                    cnt_q      <= '0;
                end
            end
            else
            begin
                in_frame_q <= 1'b0;
                err_seen_q <= 1'b0;
                // end of frame, dv just dropped
                if (in_frame_q)
                begin
                    done_q <= 1'b1;
                    if (frame_ok)
                        stat_q.good <= stat_q.good + 16'd1;
                    else
                        stat_q.bad <= stat_q.bad + 16'd1;
                    stat_q.last_len <= cnt_q - len_w'(4);
                    stat_q.last_xor <= xor_q;
                end
            end
        end
    end

    // payload bytes leave the delay line four bytes late
    always_ff @(posedge gmii_rx_clk_i)
    begin
        if (gmii_rx_i.en)
        begin
            if (!in_frame_q)
                xor_q <= '0;
            else
            begin
                dly_q <= {dly_q[2:0], gmii_rx_i.d};
                if (cnt_q >= len_w'(4))
                    xor_q <= xor_q ^ dly_q[3];
            end
        end
    end

    assign stat_o    = stat_q;
    assign rx_done_o = done_q;

endmodule

// ==== hw/frame_tx.sv ====
module frame_tx (
    input  logic                          gmii_tx_clk_i,
    input  logic                          rst_n_i,
    input  eth_pkg::tx_state_e            phase_i,
    input  logic [eth_pkg::max_len_w-1:0] idx_i,
    input  eth_pkg::eth_cmd_t             cmd_i,
    output eth_pkg::gmii_t                gmii_o
);

    logic [7:0]     pay_byte;
    logic [31:0]    crc;
    eth_pkg::gmii_t gmii_d;

    // payload pattern
    always_comb
    begin
        if (cmd_i.op == eth_pkg::pat_const)
            pay_byte = cmd_i.fill;
        else
            pay_byte = cmd_i.fill + idx_i[7:0];  // wraps every 256 bytes
    end

    // fcs covers the payload only
    crc32_gmii u_crc32_gmii (
        .clk_i   (gmii_tx_clk_i),
        .rst_n_i (rst_n_i),
        .init_i  (phase_i == eth_pkg::tx_sfd),
        .en_i    (phase_i == eth_pkg::tx_data),
        .data_i  (pay_byte),
        .crc_o   (crc)
    );

    always_comb
    begin
        gmii_d = '0;
        unique case (phase_i)
            eth_pkg::tx_pre:
            begin
                gmii_d.d  = 8'h55;
                gmii_d.en = 1'b1;
            end
            eth_pkg::tx_sfd:
            begin
                gmii_d.d  = eth_pkg::sfd_byte;
                gmii_d.en = 1'b1;
            end
            eth_pkg::tx_data:
            begin
                gmii_d.d  = pay_byte;
                gmii_d.en = 1'b1;
                gmii_d.er = (cmd_i.op == eth_pkg::pat_err) && (idx_i == '0);
            end
            eth_pkg::tx_fcs:
            begin
                // complemented crc, low byte first
                gmii_d.d  = ~crc[{idx_i[1:0], 3'b000} +: 8];
                gmii_d.en = 1'b1;
            end
            default:
            begin
                gmii_d = '0;  // idle and gap
            end
        endcase
    end

    always_ff @(posedge gmii_tx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            gmii_o <= '0;
        else
            gmii_o <= gmii_d;
    end

endmodule

// ==== hw/gmii_to_rgmii.sv ====
module gmii_to_rgmii #(
    parameter bit in_phase_tx_clk = 1'b0   // 1 for PHYs that want an in-phase clock
) (
    input  logic           gmii_tx_clk_i,    // from MAC
    input  logic           gmii_tx_clk90_i,  // from MAC
    input  logic           rst_n_i,
    input  eth_pkg::gmii_t gmii_tx_i,        // from MAC
    input  logic [3:0]     rgmii_rxd_i,      // from PHY
    input  logic           rgmii_rx_ctl_i,   // from PHY
    input  logic           rgmii_rx_clk_i,   // from PHY
    output logic [3:0]     rgmii_txd_o,      // to PHY
    output logic           rgmii_tx_ctl_o,   // to PHY
    output logic           rgmii_tx_clk_o,   // to PHY
    output eth_pkg::gmii_t gmii_rx_o,        // to MAC
    output logic           gmii_rx_clk_o     // to MAC
);

    logic       tx_clk_src;
    logic       tx_clk_q;
    logic [3:0] txd_rise_q;
    logic [3:0] txd_fall_pre;
    logic [3:0] txd_fall_q;
    logic       tx_ctl_rise_q;
    logic       tx_ctl_fall_pre;
    logic       tx_ctl_fall_q;
    logic [3:0] rxd_rise_pre;
    logic [3:0] rxd_fall_pre;
    logic [3:0] rxd_rise_q;
    logic [3:0] rxd_fall_q;
    logic       rx_ctl_rise_pre;
    logic       rx_ctl_fall_pre;
    logic       rx_ctl_rise_q;
    logic       rx_ctl_fall_q;

    // forwarded clock, ddr output with 1 on the high phase and 0 on the low phase
    assign tx_clk_src = in_phase_tx_clk ? gmii_tx_clk_i : gmii_tx_clk90_i;

    always_ff @(posedge tx_clk_src or negedge rst_n_i)
    begin
        if (!rst_n_i)
            tx_clk_q <= 1'b0;
        else
            tx_clk_q <= 1'b1;
    end

    assign rgmii_tx_clk_o = tx_clk_src & tx_clk_q;

    // same-edge ddr out, both halves taken on the rising edge
    always_ff @(posedge gmii_tx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            tx_ctl_rise_q   <= 1'b0;
            tx_ctl_fall_pre <= 1'b0;
        end
        else
        begin
            tx_ctl_rise_q   <= gmii_tx_i.en;
            tx_ctl_fall_pre <= gmii_tx_i.en ^ gmii_tx_i.er;  // rgmii error encoding
        end
    end

    always_ff @(negedge gmii_tx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            tx_ctl_fall_q <= 1'b0;
        else
            tx_ctl_fall_q <= tx_ctl_fall_pre;
    end

    always_ff @(posedge gmii_tx_clk_i)
    begin
        txd_rise_q   <= gmii_tx_i.d[3:0];
        txd_fall_pre <= gmii_tx_i.d[7:4];
    end

    always_ff @(negedge gmii_tx_clk_i)
        txd_fall_q <= txd_fall_pre;

    assign rgmii_txd_o    = gmii_tx_clk_i ? txd_rise_q : txd_fall_q;
    assign rgmii_tx_ctl_o = gmii_tx_clk_i ? tx_ctl_rise_q : tx_ctl_fall_q;

    // receive, same-edge pipelined capture
    always_ff @(posedge rgmii_rx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rx_ctl_rise_pre <= 1'b0;
            rx_ctl_rise_q   <= 1'b0;
            rx_ctl_fall_q   <= 1'b0;
        end
        else
        begin
            rx_ctl_rise_pre <= rgmii_rx_ctl_i;
            rx_ctl_rise_q   <= rx_ctl_rise_pre;
            rx_ctl_fall_q   <= rx_ctl_fall_pre;
        end
    end

    always_ff @(negedge rgmii_rx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            rx_ctl_fall_pre <= 1'b0;
        else
            rx_ctl_fall_pre <= rgmii_rx_ctl_i;
    end

    always_ff @(posedge rgmii_rx_clk_i)
    begin
        rxd_rise_pre <= rgmii_rxd_i;
        rxd_rise_q   <= rxd_rise_pre;
        rxd_fall_q   <= rxd_fall_pre;  // realigned to the rising edge
    end

    always_ff @(negedge rgmii_rx_clk_i)
        rxd_fall_pre <= rgmii_rxd_i;

    assign gmii_rx_o = '{d:  {rxd_fall_q, rxd_rise_q},
                         en: rx_ctl_rise_q,
                         er: rx_ctl_rise_q ^ rx_ctl_fall_q};

    assign gmii_rx_clk_o = rgmii_rx_clk_i;

endmodule

// ==== src.f ====
hw/eth_pkg.sv
hw/crc32_gmii.sv
hw/eth_test_ctrl.sv
hw/frame_tx.sv
hw/gmii_to_rgmii.sv
hw/frame_rx_check.sv
hw/eth_rgmii_tester.sv
verification/tb_clk_gen.sv
verification/tb_eth_rgmii_tester.sv

// ==== verification/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int period_ns  = 40,
    parameter int rst_cycles = 3
) (
    output logic clk_o,
    output logic clk90_o,   // lags clk_o by a quarter period
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    initial
    begin
        clk90_o = 1'b0;
        #(period_ns / 4);
        forever #(period_ns / 2) clk90_o = ~clk90_o;
    end

    // released on a falling edge
    initial
    begin
        rst_n_o = 1'b0;
        #(rst_cycles * period_ns);
        rst_n_o = 1'b1;
    end

endmodule

// ==== verification/tb_eth_rgmii_tester.sv ====
module tb_eth_rgmii_tester;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          clk_period     = 40;
    localparam int          timeout_cycles = 200;       // longest frame is 88 cycles
    localparam logic [15:0] lfsr_seed      = 16'd64933;
    localparam int          len_w          = eth_pkg::max_len_w;
    localparam int          frame_overhead = eth_pkg::preamble_len + 1 + 4 + eth_pkg::ifg_cycles;

    logic              gmii_tx_clk;
    logic              gmii_tx_clk90;
    logic              rst_n;
    logic              start;
    eth_pkg::eth_cmd_t cmd;
    logic [3:0]        rgmii_txd;
    logic              rgmii_tx_ctl;
    logic              rgmii_clk;     // forwarded clock looped back as rx clock
    logic              busy;
    eth_pkg::rx_stat_t stat;
    logic              rx_done;

    // reference model state
    logic [15:0]       exp_good;
    logic [15:0]       exp_bad;
    logic [len_w-1:0]  exp_len;
    logic [7:0]        exp_xor;
    int                exp_busy_len;
    int                frames_sent;
    int                rx_frames;
    int                busy_len;       // rising edges with busy high in this frame
    int                value_errs;
    int                timeouts;
    logic [15:0]       lfsr_q;

    tb_clk_gen #(
        .period_ns  (clk_period),
        .rst_cycles (3)
    ) u_tb_clk_gen (
        .clk_o   (gmii_tx_clk),
        .clk90_o (gmii_tx_clk90),
        .rst_n_o (rst_n)
    );

    // rgmii pins wired straight back
    eth_rgmii_tester #(
        .in_phase_tx_clk (1'b0)
    ) u_eth_rgmii_tester (
        .gmii_tx_clk_i   (gmii_tx_clk),
        .gmii_tx_clk90_i (gmii_tx_clk90),
        .rst_n_i         (rst_n),
        .start_i         (start),
        .cmd_i           (cmd),
        .rgmii_txd_o     (rgmii_txd),
        .rgmii_tx_ctl_o  (rgmii_tx_ctl),
        .rgmii_tx_clk_o  (rgmii_clk),
        .rgmii_rxd_i     (rgmii_txd),
        .rgmii_rx_ctl_i  (rgmii_tx_ctl),
        .rgmii_rx_clk_i  (rgmii_clk),
        .busy_o          (busy),
        .stat_o          (stat),
        .rx_done_o       (rx_done)
    );

    always @(posedge gmii_tx_clk or negedge rst_n)
    begin
        if (!rst_n)
            busy_len <= 0;
        else if (busy)
            busy_len <= busy_len + 1;
        else
            busy_len <= 0;
    end

    always @(posedge rgmii_clk or negedge rst_n)
    begin
        if (!rst_n)
            rx_frames <= 0;
        else if (rx_done)
            rx_frames <= rx_frames + 1;
    end

    a_reset_idle : assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
        (frames_sent == 0) |-> (!busy && !rgmii_tx_ctl && !rx_done && stat == '0))
    else
    begin
        value_errs = value_errs + 1;
        $display("error: after reset busy_o = %h, rgmii_tx_ctl = %h, rx_done_o = %h, stat_o = %h",
                 $sampled(busy), $sampled(rgmii_tx_ctl), $sampled(rx_done), $sampled(stat));
    end

    a_good : assert property (@(posedge rgmii_clk) disable iff (!rst_n)
        rx_done |-> (stat.good == exp_good))
    else
    begin
        value_errs = value_errs + 1;
        $display("error: stat_o.good = %h, expected %h", $sampled(stat.good), exp_good);
    end

    a_bad : assert property (@(posedge rgmii_clk) disable iff (!rst_n)
        rx_done |-> (stat.bad == exp_bad))
    else
    begin
        value_errs = value_errs + 1;
        $display("error: stat_o.bad = %h, expected %h", $sampled(stat.bad), exp_bad);
    end

    a_last_len : assert property (@(posedge rgmii_clk) disable iff (!rst_n)
        rx_done |-> (stat.last_len == exp_len))
    else
    begin
        value_errs = value_errs + 1;
        $display("error: stat_o.last_len = %h, expected %h", $sampled(stat.last_len), exp_len);
    end

    a_last_xor : assert property (@(posedge rgmii_clk) disable iff (!rst_n)
        rx_done |-> (stat.last_xor == exp_xor))
    else
    begin
        value_errs = value_errs + 1;
        $display("error: stat_o.last_xor = %h, expected %h", $sampled(stat.last_xor), exp_xor);
    end

    // every done pulse belongs to an accepted command
    a_one_frame : assert property (@(posedge rgmii_clk) disable iff (!rst_n)
        rx_done |-> (rx_frames < frames_sent))
    else
    begin
        value_errs = value_errs + 1;
        $display("error: rx frame count = %h, frames sent = %h", $sampled(rx_frames) + 1,
                 frames_sent);
    end

    a_busy_len : assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
        $fell(busy) |-> (busy_len == exp_busy_len))
    else
    begin
        value_errs = value_errs + 1;
        $display("error: busy_o length = %h, expected %h", $sampled(busy_len), exp_busy_len);
    end

    // forwarded clock low before each rising edge and high before each falling edge
    a_clk_low : assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
        busy |-> !rgmii_clk)
    else
    begin
        value_errs = value_errs + 1;
        $display("error: rgmii_tx_clk = %h at rising gmii_tx_clk, expected 0",
                 $sampled(rgmii_clk));
    end

    a_clk_high : assert property (@(negedge gmii_tx_clk) disable iff (!rst_n)
        busy |-> rgmii_clk)
    else
    begin
        value_errs = value_errs + 1;
        $display("error: rgmii_tx_clk = %h at falling gmii_tx_clk, expected 1",
                 $sampled(rgmii_clk));
    end

    // preamble reaches the pins two cycles after the accept edge
    a_ctl_pre : assert property (@(negedge gmii_tx_clk) disable iff (!rst_n)
        (busy && busy_len >= 2 && busy_len <= eth_pkg::preamble_len + 1) |-> rgmii_tx_ctl)
    else
    begin
        value_errs = value_errs + 1;
        $display("error: rgmii_tx_ctl = %h in preamble byte %0d, expected 1",
                 $sampled(rgmii_tx_ctl), $sampled(busy_len) - 2);
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        else
            return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v      = {v[14:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic pick_len_fill(output int len, output logic [7:0] fill);
        logic [15:0] r;
        take_bits(6, r);
        len = int'(r) + 1;   // 1 to 64
        take_bits(8, r);
        fill = r[7:0];
    endtask

    function automatic logic [7:0] pattern_xor(eth_pkg::pat_op_e op, int len,
                                               logic [7:0] fill);
        logic [7:0] acc;
        acc = 8'h00;
        if (op == eth_pkg::pat_const)
            acc = (len % 2 == 1) ? fill : 8'h00;   // equal pairs cancel
        else
        begin
            for (int k = 0; k < len; k++)
            begin
                acc = acc ^ (fill + 8'(k));
            end
        end
        return acc;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge gmii_tx_clk);
    endtask

    task automatic send_frame(input eth_pkg::pat_op_e op, input int len, input logic [7:0] fill);
        @(negedge gmii_tx_clk);
        if (op == eth_pkg::pat_err)
            exp_bad = exp_bad + 16'd1;
        else
            exp_good = exp_good + 16'd1;
        exp_len      = len_w'(len);
        exp_xor      = pattern_xor(op, len, fill);
        exp_busy_len = frame_overhead + len;
        frames_sent  = frames_sent + 1;
        cmd.op       = op;
        cmd.len      = len_w'(len);
        cmd.fill     = fill;
        start        = 1'b1;
        @(negedge gmii_tx_clk);
        start = 1'b0;
    endtask

    // these land while busy and must be dropped
    task automatic extra_starts(input int n);
        repeat (n)
        begin
            @(negedge gmii_tx_clk);
            cmd.op   = eth_pkg::pat_const;
            cmd.fill = ~cmd.fill;
            start    = 1'b1;
            @(negedge gmii_tx_clk);
            start = 1'b0;
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < timeout_cycles)
        begin
            @(negedge gmii_tx_clk);
            n++;
        end
        if (rst_n !== 1'b1)
        begin
            timeouts = timeouts + 1;
            $display("timeout: reset was never released");
        end
    endtask

    task automatic wait_frames_received();
        int n;
        n = 0;
        while (rx_frames < frames_sent && n < timeout_cycles)
        begin
            @(negedge gmii_tx_clk);
            n++;
        end
        if (rx_frames < frames_sent)
        begin
            timeouts = timeouts + 1;
            $display("timeout: frame %0d never came back on the receive side", frames_sent);
        end
    endtask

    task automatic wait_tx_idle();
        int n;
        n = 0;
        while (busy && n < timeout_cycles)
        begin
            @(negedge gmii_tx_clk);
            n++;
        end
        if (busy)
        begin
            timeouts = timeouts + 1;
            $display("timeout: busy_o stayed high for %0d cycles", timeout_cycles);
        end
    endtask

    task automatic run_frame(input eth_pkg::pat_op_e op, input int len, input logic [7:0] fill);
        send_frame(op, len, fill);
        wait_frames_received();
        wait_tx_idle();
    endtask

    initial
    begin
        int         len;
        logic [7:0] fill;

        start        = 1'b0;
        cmd          = '0;
        lfsr_q       = lfsr_seed;
        exp_good     = '0;
        exp_bad      = '0;
        exp_len      = '0;
        exp_xor      = '0;
        exp_busy_len = 0;
        frames_sent  = 0;
        value_errs   = 0;
        timeouts     = 0;

        wait_reset_release();
        idle_cycles(4);   // a_reset_idle watches here

        repeat (3)
        begin
            pick_len_fill(len, fill);
            run_frame(eth_pkg::pat_incr, len, fill);
        end

        // constant pattern with one odd and one even length
        pick_len_fill(len, fill);
        run_frame(eth_pkg::pat_const, len, fill);
        len = (len % 2 == 1) ? len + 1 : len - 1;
        run_frame(eth_pkg::pat_const, len, fill);

        pick_len_fill(len, fill);
        run_frame(eth_pkg::pat_err, len, fill);

        // starts during a frame
        pick_len_fill(len, fill);
        send_frame(eth_pkg::pat_incr, len, fill);
        extra_starts(3);
        wait_frames_received();
        wait_tx_idle();
        idle_cycles(60);   // a frame from a dropped start would arrive here

        pick_len_fill(len, fill);
        run_frame(eth_pkg::pat_incr, len, fill);
        idle_cycles(60);   // room for a stray frame to show up

        $display("summary: %0d value errors, %0d timeouts", value_errs, timeouts);
        if (value_errs == 0 && timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
